//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/insn_decoder.sv
      - src/rename_unit.sv
      - src/alu_rs.sv
      - src/alu_unit.sv
      - src/reorder_buffer.sv
      - src/ooo_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/core_assert.sv
      - test/core_tb.sv

//--- src/alu_rs.sv
`default_nettype none

`include "core_macros.svh"

module alu_rs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              disp_valid_i,
  input  core_pkg::dispatch_t               disp_i,
  input  core_pkg::result_t                 result_i,
  output logic                              issue_valid_o,
  output core_pkg::dispatch_t               issue_o,
  output logic [$clog2(`CORE_RS_NUM+1)-1:0] free_cnt_o
);
  import core_pkg::*;

  localparam int rs_sel_w = $clog2(`CORE_RS_NUM);

  dispatch_t               ent_q [`CORE_RS_NUM];
  logic [`CORE_RS_NUM-1:0] valid_q;
  // older_q[i][j] set when entry i is older than entry j
  logic [`CORE_RS_NUM-1:0] older_q [`CORE_RS_NUM];
  logic [`CORE_RS_NUM-1:0] ready_vec;
  logic [rs_sel_w-1:0]     issue_sel;
  logic [rs_sel_w-1:0]     write_sel;

  function automatic dispatch_t wake(input dispatch_t ent, input result_t res);
    dispatch_t w;
    w = ent;
    if (res.valid && !w.rdy1 && w.op1[`CORE_RRF_SEL-1:0] == res.rrf_tag) begin
      w.op1  = res.data;
      w.rdy1 = 1'b1;
    end
    if (res.valid && !w.rdy2 && w.op2[`CORE_RRF_SEL-1:0] == res.rrf_tag) begin
      w.op2  = res.data;
      w.rdy2 = 1'b1;
    end
    return w;
  endfunction

  always_comb begin
    logic blocked;
    issue_valid_o = 1'b0;
    issue_sel     = '0;
    write_sel     = '0;
    free_cnt_o    = '0;
    for (int i = 0; i < `CORE_RS_NUM; i++) begin
      ready_vec[i] = valid_q[i] && ent_q[i].rdy1 && ent_q[i].rdy2;
      if (!valid_q[i]) begin
        free_cnt_o = free_cnt_o + 1'b1;
      end
    end
    // Lowest free slot
    for (int i = `CORE_RS_NUM-1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        write_sel = rs_sel_w'(i);
      end
    end
    // Oldest ready entry
    for (int i = 0; i < `CORE_RS_NUM; i++) begin
      blocked = 1'b0;
      for (int j = 0; j < `CORE_RS_NUM; j++) begin
        if (ready_vec[j] && older_q[j][i]) begin
          blocked = 1'b1;
        end
      end
      if (ready_vec[i] && !blocked) begin
        issue_valid_o = 1'b1;
        issue_sel     = rs_sel_w'(i);
      end
    end
    issue_o = ent_q[issue_sel];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      for (int i = 0; i < `CORE_RS_NUM; i++) begin
        older_q[i] <= '0;
      end
    end else begin
      if (issue_valid_o) begin
        valid_q[issue_sel] <= 1'b0;
      end
      if (disp_valid_i) begin
        valid_q[write_sel] <= 1'b1;
        for (int j = 0; j < `CORE_RS_NUM; j++) begin
          older_q[j][write_sel] <= 1'b1;
        end
        older_q[write_sel] <= '0;
      end
    end
  end

  // Wakeup also applies to the entry being written
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `CORE_RS_NUM; i++) begin
      ent_q[i] <= wake(ent_q[i], result_i);
    end
    if (disp_valid_i) begin
      ent_q[write_sel] <= wake(disp_i, result_i);
    end
  end

endmodule

`default_nettype wire

//--- src/alu_unit.sv
`default_nettype none

`include "core_macros.svh"

module alu_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                issue_valid_i,
  input  core_pkg::dispatch_t issue_i,
  output core_pkg::result_t   result_o
);
  import core_pkg::*;

  data_t alu_out;

  always_comb begin
    case (issue_i.alu_op)
      ALU_SUB:  alu_out = issue_i.op1 - issue_i.op2;
      ALU_SLL:  alu_out = issue_i.op1 << issue_i.op2[4:0];
      ALU_SLT:  alu_out = {{(`CORE_XLEN-1){1'b0}},
                           $signed(issue_i.op1) < $signed(issue_i.op2)};
      ALU_SLTU: alu_out = {{(`CORE_XLEN-1){1'b0}}, issue_i.op1 < issue_i.op2};
      ALU_XOR:  alu_out = issue_i.op1 ^ issue_i.op2;
      ALU_SRL:  alu_out = issue_i.op1 >> issue_i.op2[4:0];
      ALU_SRA:  alu_out = $signed(issue_i.op1) >>> issue_i.op2[4:0];
      ALU_OR:   alu_out = issue_i.op1 | issue_i.op2;
      ALU_AND:  alu_out = issue_i.op1 & issue_i.op2;
      default:  alu_out = issue_i.op1 + issue_i.op2;
    endcase
  end

  always_ff @(posedge clk_i) begin
    result_o.rrf_tag <= issue_i.rrf_tag;
    // No destination register means nothing to report
    result_o.data    <= issue_i.wr_reg ? alu_out : '0;
    if (!rst_n_i) begin
      result_o.valid <= 1'b0;
    end else begin
      result_o.valid <= issue_valid_i;
    end
  end

endmodule

`default_nettype wire

//--- src/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width
`define CORE_XLEN 32

// Rename registers and ROB entries share one tag space
`define CORE_RRF_NUM 8
`define CORE_RRF_SEL 3

// Reservation station depth
`define CORE_RS_NUM 4

`endif

//--- src/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] data_t;
  typedef logic [4:0] reg_sel_t;
  typedef logic [`CORE_RRF_SEL-1:0] rrf_tag_t;
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  typedef struct packed {
    alu_op_t  alu_op;
    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     uses_imm;
    data_t    imm;
    logic     wr_reg;
  } decoded_t;

  // Operands not yet ready hold the producer tag in their low bits
  typedef struct packed {
    alu_op_t  alu_op;
    data_t    op1;
    logic     rdy1;
    data_t    op2;
    logic     rdy2;
    rrf_tag_t rrf_tag;
    logic     wr_reg;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    rrf_tag_t rrf_tag;
    data_t    data;
  } result_t;

  typedef struct packed {
    logic     valid;
    rrf_tag_t rrf_tag;
    reg_sel_t rd;
    logic     wr_reg;
  } commit_t;

endpackage

`default_nettype wire

//--- src/insn_decoder.sv
`default_nettype none

`include "core_macros.svh"

module insn_decoder (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               insn_valid_i,
  input  logic [31:0]        insn_i,
  output logic               dec_valid_o,
  output core_pkg::decoded_t dec_o
);
  import core_pkg::*;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       is_op;
  decoded_t   dec_d;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt    = insn_i[30];
  assign is_op  = (opcode == opc_op);

  always_comb begin
    dec_d.rd       = insn_i[11:7];
    dec_d.rs1      = insn_i[19:15];
    dec_d.rs2      = insn_i[24:20];
    dec_d.uses_rs1 = 1'b1;
    dec_d.uses_rs2 = is_op;
    dec_d.uses_imm = !is_op;
    dec_d.wr_reg   = is_op || (opcode == opc_op_imm);
    dec_d.imm      = {{(`CORE_XLEN-12){insn_i[31]}}, insn_i[31:20]};
    case (funct3)
      3'b000:  dec_d.alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  dec_d.alu_op = ALU_SLL;
      3'b010:  dec_d.alu_op = ALU_SLT;
      3'b011:  dec_d.alu_op = ALU_SLTU;
      3'b100:  dec_d.alu_op = ALU_XOR;
      3'b101:  dec_d.alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  dec_d.alu_op = ALU_OR;
      default: dec_d.alu_op = ALU_AND;
    endcase
    // Shift immediates carry only shamt
    if (funct3 == 3'b001 || funct3 == 3'b101) begin
      dec_d.imm = data_t'(insn_i[24:20]);
    end
  end

  always_ff @(posedge clk_i) begin
    dec_o <= dec_d;
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= insn_valid_i;
    end
  end

endmodule

`default_nettype wire

//--- src/ooo_core_top.sv
`default_nettype none

`include "core_macros.svh"

module ooo_core_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               insn_valid_i,
  input  logic [31:0]        insn_i,
  output logic               dispatch_ready_o,
  output logic               commit_valid_o,
  output core_pkg::reg_sel_t commit_rd_o,
  output core_pkg::data_t    commit_data_o
);
  import core_pkg::*;

  logic                               dec_valid;
  decoded_t                           dec;
  logic                               disp_valid;
  dispatch_t                          disp;
  commit_t                            alloc;
  logic                               issue_valid;
  dispatch_t                          issue;
  result_t                            result;
  commit_t                            commit;
  logic [$clog2(`CORE_RS_NUM+1)-1:0]  rs_free;

  insn_decoder u_insn_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec)
  );

  rename_unit u_rename_unit (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dec_valid_i      (dec_valid),
    .dec_i            (dec),
    .result_i         (result),
    .commit_i         (commit),
    .rs_free_i        (rs_free),
    .disp_valid_o     (disp_valid),
    .disp_o           (disp),
    .alloc_o          (alloc),
    .dispatch_ready_o (dispatch_ready_o),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o)
  );

  alu_rs u_alu_rs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .disp_valid_i  (disp_valid),
    .disp_i        (disp),
    .result_i      (result),
    .issue_valid_o (issue_valid),
    .issue_o       (issue),
    .free_cnt_o    (rs_free)
  );

  alu_unit u_alu_unit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .result_o      (result)
  );

  reorder_buffer u_reorder_buffer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .alloc_i  (alloc),
    .result_i (result),
    .commit_o (commit)
  );

endmodule

`default_nettype wire

//--- src/rename_unit.sv
`default_nettype none

`include "core_macros.svh"

module rename_unit (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                dec_valid_i,
  input  core_pkg::decoded_t                  dec_i,
  input  core_pkg::result_t                   result_i,
  input  core_pkg::commit_t                   commit_i,
  input  logic [$clog2(`CORE_RS_NUM+1)-1:0]   rs_free_i,
  output logic                                disp_valid_o,
  output core_pkg::dispatch_t                 disp_o,
  output core_pkg::commit_t                   alloc_o,
  output logic                                dispatch_ready_o,
  output logic                                commit_valid_o,
  output core_pkg::reg_sel_t                  commit_rd_o,
  output core_pkg::data_t                     commit_data_o
);
  import core_pkg::*;

  localparam int rs_cnt_w = $clog2(`CORE_RS_NUM+1);
  localparam logic [`CORE_XLEN:0] zero_rdy = {1'b1, {`CORE_XLEN{1'b0}}};

  data_t                   arf_data_q [32];
  logic [31:0]             arf_busy_q;
  rrf_tag_t                arf_tag_q [32];
  data_t                   rrf_data_q [`CORE_RRF_NUM];
  logic [`CORE_RRF_NUM-1:0] rrf_valid_q;
  rrf_tag_t                alloc_ptr_q;
  logic [`CORE_RRF_SEL:0]  free_cnt_q;
  logic [rs_cnt_w-1:0]     rs_avail;
  logic [`CORE_XLEN:0]     src1;
  logic [`CORE_XLEN:0]     src2;
  dispatch_t               disp_d;

  // Returns {ready, value or producer tag}
  function automatic logic [`CORE_XLEN:0] read_src(input reg_sel_t rs);
    rrf_tag_t tag;
    tag = arf_tag_q[rs];
    if (rs == '0) begin
      return zero_rdy;
    end else if (!arf_busy_q[rs]) begin
      return {1'b1, arf_data_q[rs]};
    end else if (rrf_valid_q[tag]) begin
      return {1'b1, rrf_data_q[tag]};
    end else if (result_i.valid && result_i.rrf_tag == tag) begin
      return {1'b1, result_i.data};
    end
    return {1'b0, data_t'(tag)};
  endfunction

  // The entry held in disp_o has not reached the station yet
  assign rs_avail = rs_free_i - {{(rs_cnt_w-1){1'b0}}, disp_valid_o};
  assign dispatch_ready_o = (free_cnt_q >= 2) && (rs_avail >= 2);

  always_comb begin
    src1 = dec_i.uses_rs1 ? read_src(dec_i.rs1) : zero_rdy;
    if (dec_i.uses_imm) begin
      src2 = {1'b1, dec_i.imm};
    end else if (dec_i.uses_rs2) begin
      src2 = read_src(dec_i.rs2);
    end else begin
      src2 = zero_rdy;
    end
    disp_d.alu_op  = dec_i.alu_op;
    disp_d.op1     = src1[`CORE_XLEN-1:0];
    disp_d.rdy1    = src1[`CORE_XLEN];
    disp_d.op2     = src2[`CORE_XLEN-1:0];
    disp_d.rdy2    = src2[`CORE_XLEN];
    disp_d.rrf_tag = alloc_ptr_q;
    disp_d.wr_reg  = dec_i.wr_reg;
  end

  always_ff @(posedge clk_i) begin
    alloc_o.rrf_tag <= alloc_ptr_q;
    alloc_o.rd      <= dec_i.rd;
    alloc_o.wr_reg  <= dec_i.wr_reg;
    if (!rst_n_i) begin
      disp_valid_o   <= 1'b0;
      alloc_o.valid  <= 1'b0;
      commit_valid_o <= 1'b0;
      arf_busy_q     <= '0;
      rrf_valid_q    <= '0;
      alloc_ptr_q    <= '0;
      free_cnt_q     <= (`CORE_RRF_SEL+1)'(`CORE_RRF_NUM);
      for (int i = 0; i < 32; i++) begin
        arf_data_q[i] <= '0;
      end
    end else begin
      disp_valid_o   <= dec_valid_i;
      alloc_o.valid  <= dec_valid_i;
      commit_valid_o <= commit_i.valid;
      case ({dec_valid_i, commit_i.valid})
        2'b10:   free_cnt_q <= free_cnt_q - 1'b1;
        2'b01:   free_cnt_q <= free_cnt_q + 1'b1;
        default: free_cnt_q <= free_cnt_q;
      endcase
      if (result_i.valid) begin
        rrf_valid_q[result_i.rrf_tag] <= 1'b1;
      end
      if (commit_i.valid && commit_i.wr_reg && commit_i.rd != '0) begin
        arf_data_q[commit_i.rd] <= rrf_data_q[commit_i.rrf_tag];
        // A younger writer keeps the register busy
        if (arf_tag_q[commit_i.rd] == commit_i.rrf_tag) begin
          arf_busy_q[commit_i.rd] <= 1'b0;
        end
      end
      // Allocation after commit so a new mapping of rd wins
      if (dec_valid_i) begin
        rrf_valid_q[alloc_ptr_q] <= 1'b0;
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
        if (dec_i.wr_reg && dec_i.rd != '0) begin
          arf_busy_q[dec_i.rd] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    disp_o        <= disp_d;
    commit_rd_o   <= commit_i.rd;
    commit_data_o <= (commit_i.wr_reg && commit_i.rd != '0) ?
                     rrf_data_q[commit_i.rrf_tag] : '0;
    if (result_i.valid) begin
      rrf_data_q[result_i.rrf_tag] <= result_i.data;
    end
    if (dec_valid_i && dec_i.wr_reg && dec_i.rd != '0) begin
      arf_tag_q[dec_i.rd] <= alloc_ptr_q;
    end
  end

endmodule

`default_nettype wire

//--- src/reorder_buffer.sv
`default_nettype none

`include "core_macros.svh"

module reorder_buffer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  core_pkg::commit_t alloc_i,
  input  core_pkg::result_t result_i,
  output core_pkg::commit_t commit_o
);
  import core_pkg::*;

  logic [`CORE_RRF_NUM-1:0] alloc_q;
  logic [`CORE_RRF_NUM-1:0] fin_q;
  logic [`CORE_RRF_NUM-1:0] wr_reg_q;
  reg_sel_t                 rd_q [`CORE_RRF_NUM];
  rrf_tag_t                 commit_ptr_q;

  always_comb begin
    commit_o.valid   = alloc_q[commit_ptr_q] && fin_q[commit_ptr_q];
    commit_o.rrf_tag = commit_ptr_q;
    commit_o.rd      = rd_q[commit_ptr_q];
    commit_o.wr_reg  = wr_reg_q[commit_ptr_q];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alloc_q      <= '0;
      commit_ptr_q <= '0;
    end else begin
      if (alloc_i.valid) begin
        alloc_q[alloc_i.rrf_tag] <= 1'b1;
      end
      if (commit_o.valid) begin
        alloc_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q <= commit_ptr_q + 1'b1;
      end
    end
  end

  // Finished flag only counts while the entry is allocated
  always_ff @(posedge clk_i) begin
    if (alloc_i.valid) begin
      fin_q[alloc_i.rrf_tag]    <= 1'b0;
      rd_q[alloc_i.rrf_tag]     <= alloc_i.rd;
      wr_reg_q[alloc_i.rrf_tag] <= alloc_i.wr_reg;
    end
    if (result_i.valid) begin
      fin_q[result_i.rrf_tag] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- test/core_assert.sv
`default_nettype none

`include "core_macros.svh"

module core_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic insn_valid_i,
  input logic dispatch_ready_i,
  input logic commit_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Oldest instruction in flight always reaches commit within this
  localparam int min_latency   = 6;
  localparam int commit_window = `CORE_RRF_NUM + min_latency;

  int fail_cnt = 0;

  commit_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(commit_valid_i)
  ) else begin
    $error("commit_valid_o is unknown");
    fail_cnt++;
  end

  strobe_only_when_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(insn_valid_i && !dispatch_ready_i)
  ) else begin
    $error("insn_valid_i high while dispatch_ready_o is low");
    fail_cnt++;
  end

  commit_follows_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    insn_valid_i |-> ##[1:commit_window] commit_valid_i
  ) else begin
    $error("no commit within %0d cycles of an accepted instruction", commit_window);
    fail_cnt++;
  end

endmodule

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int clk_half = 20;
  localparam int n_setup  = 31;
  localparam int n_ops    = 19;
  localparam int n_chain  = 24;
  localparam int n_x0     = 8;
  localparam int n_random = 200;
  localparam int n_total  = n_setup + n_ops + n_chain + n_x0 + n_random;
  localparam int watchdog_cycles = n_total * 20 + 200;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  // {alt, funct3} of the ten register forms
  localparam logic [3:0] r_forms [10] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                                          4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};

  typedef struct packed {
    reg_sel_t rd;
    data_t    data;
  } exp_t;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        insn_valid_i;
  logic [31:0] insn_i;
  logic        dispatch_ready_o;
  logic        commit_valid_o;
  reg_sel_t    commit_rd_o;
  data_t       commit_data_o;

  data_t       arf_model [32];
  exp_t        exp_q [$];
  logic [31:0] rng;
  logic        prev_strobe = 1'b0;
  string       test_name;
  int          err_cnt;
  int          accept_cnt;
  int          commit_cnt;

  ooo_core_top DUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n_i),
    .insn_valid_i     (insn_valid_i),
    .insn_i           (insn_i),
    .dispatch_ready_o (dispatch_ready_o),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o)
  );

  bind ooo_core_top core_assert u_core_assert (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .insn_valid_i     (insn_valid_i),
    .dispatch_ready_i (dispatch_ready_o),
    .commit_valid_i   (commit_valid_o)
  );

  always #clk_half clk = ~clk;

  always @(posedge clk) begin
    prev_strobe <= insn_valid_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_u32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // RV32I integer semantics
  function automatic data_t alu_model(input logic [2:0] f3, input logic alt,
                                      input data_t a, input data_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                        input reg_sel_t rd, input reg_sel_t rs1,
                                        input reg_sel_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input reg_sel_t rd,
                                        input reg_sel_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  // Shift immediates keep only shamt and the arithmetic bit
  function automatic logic [11:0] form_imm(input logic [2:0] f3, input logic arith,
                                           input logic [11:0] raw);
    if (f3 == 3'b001 || f3 == 3'b101) begin
      return {1'b0, arith, 5'b0, raw[4:0]};
    end
    return raw;
  endfunction

  // Strobe only after a cycle with ready high and no strobe two cycles back
  task automatic send_insn(input logic [31:0] insn, input reg_sel_t rd, input data_t value);
    exp_t e;
    if (rd != 5'd0) begin
      arf_model[rd] = value;
    end
    e.rd   = rd;
    e.data = (rd == 5'd0) ? '0 : value;
    exp_q.push_back(e);
    @(negedge clk);
    while (!dispatch_ready_o || prev_strobe) begin
      @(posedge clk);
      insn_valid_i <= 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    insn_valid_i <= 1'b1;
    insn_i       <= insn;
    accept_cnt++;
  endtask

  task automatic exec_r(input logic [2:0] f3, input logic alt, input reg_sel_t rd,
                        input reg_sel_t rs1, input reg_sel_t rs2);
    send_insn(enc_r(f3, alt, rd, rs1, rs2), rd,
              alu_model(f3, alt, arf_model[rs1], arf_model[rs2]));
  endtask

  task automatic exec_i(input logic [2:0] f3, input reg_sel_t rd, input reg_sel_t rs1,
                        input logic [11:0] imm);
    data_t b;
    logic  alt;
    alt = 1'b0;
    b   = {{20{imm[11]}}, imm};
    if (f3 == 3'b001 || f3 == 3'b101) begin
      b   = data_t'(imm[4:0]);
      alt = imm[10];
    end
    send_insn(enc_i(f3, rd, rs1, imm), rd, alu_model(f3, alt, arf_model[rs1], b));
  endtask

  task automatic exec_random(input reg_sel_t rd, input reg_sel_t rs1, input reg_sel_t rs2);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    r   = rand_u32();
    f3  = r[3:1];
    alt = r[4] && (f3 == 3'b000 || f3 == 3'b101);
    if (r[0]) begin
      exec_r(f3, alt, rd, rs1, rs2);
    end else begin
      exec_i(f3, rd, rs1, form_imm(f3, alt, r[31:20]));
    end
  endtask

  task automatic drain();
    @(posedge clk);
    insn_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d checks, %0d assertions; %0d accepted, %0d committed",
             err_cnt, DUT.u_core_assert.fail_cnt, accept_cnt, commit_cnt);
  endtask

  // Commit checker against the in-order model queue
  always @(negedge clk) begin
    exp_t e;
    if (rst_n_i === 1'b1 && commit_valid_o === 1'b1) begin
      commit_cnt++;
      if (exp_q.size() == 0) begin
        $display("%s: a commit arrived with no instruction outstanding", test_name);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        assert (commit_rd_o === e.rd) else begin
          $display("ERR %s: rd expected %0d actual %0d", test_name, e.rd, commit_rd_o);
          err_cnt++;
        end
        assert (commit_data_o === e.data) else begin
          $display("ERR %s: data expected %h actual %h", test_name, e.data, commit_data_o);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: commits stopped with %0d of %0d accepted instructions committed",
             commit_cnt, accept_cnt);
    report_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] v;
    logic [2:0]  f3;
    reg_sel_t    prev;
    rng          = 32'h7fc5_df31;
    rst_n_i      = 1'b0;
    insn_valid_i = 1'b0;
    insn_i       = '0;
    err_cnt      = 0;
    accept_cnt   = 0;
    commit_cnt   = 0;
    for (int i = 0; i < 32; i++) begin
      arf_model[i] = '0;
    end

    test_name = "reset";
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      assert (commit_valid_o === 1'b0) else begin
        $display("ERR %s: commit_valid_o expected 0 actual %b", test_name, commit_valid_o);
        err_cnt++;
      end
      assert (dispatch_ready_o === 1'b1) else begin
        $display("ERR %s: dispatch_ready_o expected 1 actual %b", test_name,
                 dispatch_ready_o);
        err_cnt++;
      end
    end

    test_name = "seed registers";
    for (int r = 1; r < 32; r++) begin
      v = rand_u32();
      exec_i(3'b000, reg_sel_t'(r), 5'd0, v[11:0]);
    end
    drain();

    // Sources in x1..x12, destinations in x13..x31
    test_name = "every ALU operation";
    for (int k = 0; k < 10; k++) begin
      v = rand_u32();
      exec_r(r_forms[k][2:0], r_forms[k][3], reg_sel_t'(13 + k),
             reg_sel_t'(1 + v[7:0] % 12), reg_sel_t'(1 + v[15:8] % 12));
    end
    for (int k = 0; k < 9; k++) begin
      v  = rand_u32();
      f3 = (k == 8) ? 3'b101 : 3'(k);
      exec_i(f3, reg_sel_t'(23 + k), reg_sel_t'(1 + v[7:0] % 12),
             form_imm(f3, k == 8, v[31:20]));
    end
    drain();

    test_name = "dependent chain";
    prev = 5'd3;
    for (int k = 0; k < 16; k++) begin
      v = rand_u32();
      exec_random(reg_sel_t'(1 + v[12:8] % 31), prev, k[0] ? prev : reg_sel_t'(v[17:13]));
      prev = reg_sel_t'(1 + v[12:8] % 31);
    end
    for (int k = 0; k < 8; k++) begin
      exec_i(3'b000, 5'd12, 5'd12, 12'(k + 1));
    end
    drain();

    test_name = "x0 handling";
    exec_i(3'b000, 5'd0, 5'd5, 12'h123);
    exec_r(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
    exec_r(3'b000, 1'b0, 5'd6, 5'd0, 5'd0);
    exec_i(3'b110, 5'd7, 5'd0, 12'h5a5);
    exec_r(3'b000, 1'b1, 5'd8, 5'd0, 5'd9);
    exec_i(3'b000, 5'd0, 5'd1, 12'h7ff);
    exec_r(3'b000, 1'b0, 5'd10, 5'd0, 5'd1);
    exec_r(3'b100, 1'b0, 5'd0, 5'd0, 5'd0);
    drain();

    // Small register pool keeps dependencies dense
    test_name = "random stream";
    for (int k = 0; k < n_random; k++) begin
      v = rand_u32();
      exec_random(reg_sel_t'(v[2:0]), reg_sel_t'(v[5:3]), reg_sel_t'(v[8:6]));
    end
    drain();
    assert (commit_cnt == accept_cnt) else begin
      $display("ERR %s: commit count expected %0d actual %0d", test_name, accept_cnt,
               commit_cnt);
      err_cnt++;
    end

    repeat (2) @(posedge clk);
    report_counts();
    if (err_cnt == 0 && DUT.u_core_assert.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/core_pkg.sv
src/insn_decoder.sv
src/rename_unit.sv
src/alu_rs.sv
src/alu_unit.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
test/core_assert.sv
test/core_tb.sv
